// File: cdr_defs.svh
`ifndef CDR_DEFS_SVH
`define CDR_DEFS_SVH

// loop filter widths
`define CDR_PHASE_W     16  // phase integrator
`define CDR_FREQ_W      16  // frequency integrator
`define CDR_CODE_W      11  // interpolator code, top of phase

// decision buffering
`define CDR_FIFO_DEPTH  8

// gains out of reset
`define CDR_PHUG_RST    8
`define CDR_FRUG_RST    3

// register port
`define CDR_AXIL_AW     32
`define CDR_AXIL_DW     32

`define CDR_ADDR_CTRL   32'h0000_0000  // freeze
`define CDR_ADDR_GAIN   32'h0000_0004  // phug / frug
`define CDR_ADDR_CODE   32'h0000_0008  // ro
`define CDR_ADDR_FREQ   32'h0000_000C  // ro
`define CDR_ADDR_STAT   32'h0000_0010  // sticky overflow, w1c

`endif

// File: cdr_pkg.sv
`include "cdr_defs.svh"

package cdr_pkg;

  // phase detector verdict per unit interval
  typedef enum logic [1:0] {
    DEC_NONE  = 2'b00,  // no transition or invalid pattern
    DEC_EARLY = 2'b01,
    DEC_LATE  = 2'b10
  } decision_e;

  // one unit interval from the samplers
  typedef struct packed {
    logic data_bit;  // center sample
    logic edge_bit;  // transition sample
  } sample_t;

  // fifo payload
  typedef struct packed {
    decision_e dir;
  } decision_t;

  // software controlled loop settings
  typedef struct packed {
    logic [7:0] phug;    // proportional gain
    logic [7:0] frug;    // integral gain
    logic       freeze;  // stalls the filter
  } loop_cfg_t;

  // readable loop status
  typedef struct packed {
    logic [`CDR_CODE_W-1:0] code;
    logic [`CDR_FREQ_W-1:0] freq;
    logic                   overflow;  // sticky copy
  } loop_stat_t;

endpackage

// File: axil_pkg.sv
`include "cdr_defs.svh"

package axil_pkg;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10  // unmapped address
  } axil_resp_e;

  typedef struct packed {
    logic [`CDR_AXIL_AW-1:0] addr;
    logic                    valid;
  } axil_ax_t;  // shared by aw and ar

  typedef struct packed {
    logic [`CDR_AXIL_DW-1:0]   data;
    logic [`CDR_AXIL_DW/8-1:0] strb;
    logic                      valid;
  } axil_w_t;

  typedef struct packed {
    axil_resp_e resp;
    logic       valid;
  } axil_b_t;

  typedef struct packed {
    logic [`CDR_AXIL_DW-1:0] data;
    axil_resp_e              resp;
    logic                    valid;
  } axil_r_t;

  // master to slave
  typedef struct packed {
    axil_ax_t aw;
    axil_w_t  w;
    logic     b_ready;
    axil_ax_t ar;
    logic     r_ready;
  } axil_req_t;

  // slave to master
  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    axil_b_t b;
    logic    ar_ready;
    axil_r_t r;
  } axil_rsp_t;

endpackage

// File: bbpd_decider.sv
`timescale 1ns/1ps

module bbpd_decider (
  input  logic               clk,
  input  logic               rst_n,
  input  cdr_pkg::sample_t   sample,
  input  logic               sample_valid,
  output cdr_pkg::decision_t dec,
  output logic               dec_valid
);
  import cdr_pkg::*;

  logic      prev_data_q;  // data bit of the last unit interval
  logic      have_prev_q;  // first sample only primes prev_data_q
  decision_e dir_nxt;

  // alexander table on (prev data, edge, data)
  always_comb begin
    case ({prev_data_q, sample.edge_bit, sample.data_bit})
      3'b001, 3'b110: dir_nxt = DEC_EARLY;
      3'b011, 3'b100: dir_nxt = DEC_LATE;
      default:        dir_nxt = DEC_NONE;  // 000/111 no edge, 010/101 dropped
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      have_prev_q <= 1'b0;
      dec_valid   <= 1'b0;
    end else begin
      dec_valid <= sample_valid && have_prev_q && (dir_nxt != DEC_NONE);
      if (sample_valid) begin
        have_prev_q <= 1'b1;
      end
    end
  end

  // payload side
  always_ff @(posedge clk) begin
    if (sample_valid) begin
      prev_data_q <= sample.data_bit;
      dec.dir     <= dir_nxt;  // qualified by dec_valid
    end
  end

  // none decisions never leave the detector
  a_no_none: assert property (@(posedge clk) disable iff (!rst_n)
    dec_valid |-> (dec.dir != DEC_NONE));

endmodule

// File: decision_fifo.sv
`timescale 1ns/1ps
`include "cdr_defs.svh"

module decision_fifo (
  input  logic               clk,
  input  logic               rst_n,
  input  cdr_pkg::decision_t wr_dec,
  input  logic               wr_valid,
  output cdr_pkg::decision_t rd_dec,
  output logic               rd_valid,
  input  logic               rd_ready,
  output logic               overflow
);
  import cdr_pkg::*;

  localparam int DEPTH = `CDR_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  decision_t        mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic [CNT_W-1:0] count_nxt;
  logic             full;
  logic             wr_en;
  logic             rd_en;

  assign full  = (count_q == CNT_W'(DEPTH));
  assign rd_en = rd_valid && rd_ready;
  assign wr_en = wr_valid && (!full || rd_en);  // full + pop still takes the write
  assign overflow = wr_valid && full && !rd_en;  // dropped this cycle

  assign rd_dec = mem[rd_ptr_q];  // head

  always_comb begin
    case ({wr_en, rd_en})
      2'b10:   count_nxt = count_q + 1'b1;
      2'b01:   count_nxt = count_q - 1'b1;
      default: count_nxt = count_q;  // idle or push+pop
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      rd_valid <= 1'b0;
    end else begin
      count_q  <= count_nxt;
      rd_valid <= (count_nxt != '0);  // head visible next cycle
      if (wr_en) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr_q] <= wr_dec;
    end
  end

  a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
    count_q <= CNT_W'(DEPTH));

  // registered flag must track occupancy
  a_valid_count: assert property (@(posedge clk) disable iff (!rst_n)
    rd_valid == (count_q != '0));

endmodule

// File: loop_filter.sv
`timescale 1ns/1ps
`include "cdr_defs.svh"

module loop_filter (
  input  logic                   clk,
  input  logic                   rst_n,
  input  cdr_pkg::decision_t     dec,
  input  logic                   dec_valid,
  output logic                   dec_ready,
  input  cdr_pkg::loop_cfg_t     cfg,
  output logic [`CDR_CODE_W-1:0] code,
  output logic [`CDR_FREQ_W-1:0] freq
);
  import cdr_pkg::*;

  localparam int FSLICE_W = 9;  // freq bits fed into the phase path

  logic                    xfer;
  logic [`CDR_FREQ_W-1:0]  freq_q;
  logic [`CDR_FREQ_W-1:0]  freq_nxt;
  logic [`CDR_FREQ_W-1:0]  fr_term;   // integral step size
  logic [`CDR_PHASE_W-1:0] phase_q;
  logic [`CDR_PHASE_W-1:0] phase_nxt;
  logic [`CDR_PHASE_W-1:0] ph_term;   // proportional step size
  logic [`CDR_PHASE_W-1:0] fr_feed;   // sign-extended freq slice

  assign dec_ready = !cfg.freeze;  // freeze backs up into the fifo
  assign xfer      = dec_valid && dec_ready;

  assign fr_term = {{(`CDR_FREQ_W - 8){1'b0}}, cfg.frug};
  assign ph_term = {{(`CDR_PHASE_W - 8){1'b0}}, cfg.phug};

  // bits 14:6 read as signed
  assign fr_feed = {{(`CDR_PHASE_W - FSLICE_W){freq_q[`CDR_FREQ_W-2]}},
                    freq_q[`CDR_FREQ_W-2 -: FSLICE_W]};

  // s = +1 late, -1 early, everything wraps mod 2^16
  always_comb begin
    case (dec.dir)
      DEC_LATE: begin
        freq_nxt  = freq_q + fr_term;
        phase_nxt = phase_q + fr_feed + ph_term;
      end
      DEC_EARLY: begin
        freq_nxt  = freq_q - fr_term;
        phase_nxt = phase_q + fr_feed - ph_term;
      end
      default: begin  // s = 0
        freq_nxt  = freq_q;
        phase_nxt = phase_q + fr_feed;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      freq_q  <= '0;
      phase_q <= '0;
    end else if (xfer) begin
      freq_q  <= freq_nxt;
      phase_q <= phase_nxt;
    end
  end

  assign code = phase_q[`CDR_PHASE_W-1 -: `CDR_CODE_W];  // bits 15:5
  assign freq = freq_q;

  a_hold_no_xfer: assert property (@(posedge clk) disable iff (!rst_n)
    !xfer |=> ($stable(freq_q) && $stable(phase_q)));

endmodule

// File: cdr_csr_axil.sv
`timescale 1ns/1ps
`include "cdr_defs.svh"

module cdr_csr_axil (
  input  logic                   clk,
  input  logic                   rst_n,
  input  axil_pkg::axil_req_t    axil_req,
  output axil_pkg::axil_rsp_t    axil_rsp,
  input  logic [`CDR_CODE_W-1:0] stat_code,
  input  logic [`CDR_FREQ_W-1:0] stat_freq,
  input  logic                   overflow_pulse,
  output cdr_pkg::loop_cfg_t     cfg
);
  import cdr_pkg::*;
  import axil_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    WRITE_RESP,
    READ_DATA
  } csr_state_e;

  csr_state_e              state_q;
  logic                    wr_acc_q;  // aw/w ready one cycle after both valid
  logic                    wr_hs;
  logic                    ar_hs;
  logic                    wr_mapped;
  logic                    ovf_clr;
  logic                    ovf_q;
  loop_cfg_t               cfg_q;
  loop_stat_t              stat;
  logic [`CDR_AXIL_DW-1:0] rd_data;
  axil_resp_e              rd_resp;
  axil_resp_e              b_resp_q;
  logic [`CDR_AXIL_DW-1:0] r_data_q;
  axil_resp_e              r_resp_q;

  assign stat.code     = stat_code;
  assign stat.freq     = stat_freq;
  assign stat.overflow = ovf_q;

  assign wr_hs = wr_acc_q && axil_req.aw.valid && axil_req.w.valid;
  // writes win when both sides show up together
  assign ar_hs = (state_q == IDLE) && !wr_acc_q && axil_req.ar.valid &&
                 !(axil_req.aw.valid && axil_req.w.valid);

  always_comb begin
    case (axil_req.aw.addr)
      `CDR_ADDR_CTRL, `CDR_ADDR_GAIN, `CDR_ADDR_CODE,
      `CDR_ADDR_FREQ, `CDR_ADDR_STAT: wr_mapped = 1'b1;
      default:                        wr_mapped = 1'b0;
    endcase
  end

  assign ovf_clr = wr_hs && (axil_req.aw.addr == `CDR_ADDR_STAT) &&
                   axil_req.w.strb[0] && axil_req.w.data[0];

  // read mux
  always_comb begin
    rd_data = '0;
    rd_resp = RESP_OKAY;
    case (axil_req.ar.addr)
      `CDR_ADDR_CTRL: rd_data[0] = cfg_q.freeze;
      `CDR_ADDR_GAIN: rd_data[15:0] = {cfg_q.frug, cfg_q.phug};
      `CDR_ADDR_CODE: rd_data[`CDR_CODE_W-1:0] = stat.code;
      `CDR_ADDR_FREQ: rd_data[`CDR_FREQ_W-1:0] = stat.freq;
      `CDR_ADDR_STAT: rd_data[0] = stat.overflow;
      default:        rd_resp = RESP_SLVERR;
    endcase
  end

  // control registers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg_q.phug   <= 8'(`CDR_PHUG_RST);
      cfg_q.frug   <= 8'(`CDR_FRUG_RST);
      cfg_q.freeze <= 1'b0;
      ovf_q        <= 1'b0;
    end else begin
      ovf_q <= overflow_pulse || (ovf_q && !ovf_clr);  // new drop beats clear
      if (wr_hs && axil_req.aw.addr == `CDR_ADDR_CTRL && axil_req.w.strb[0]) begin
        cfg_q.freeze <= axil_req.w.data[0];
      end
      if (wr_hs && axil_req.aw.addr == `CDR_ADDR_GAIN) begin
        if (axil_req.w.strb[0]) cfg_q.phug <= axil_req.w.data[7:0];
        if (axil_req.w.strb[1]) cfg_q.frug <= axil_req.w.data[15:8];
      end
    end
  end

  // one transaction at a time
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= IDLE;
      wr_acc_q <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (wr_acc_q) begin
            wr_acc_q <= 1'b0;
            if (wr_hs) state_q <= WRITE_RESP;
          end else if (axil_req.aw.valid && axil_req.w.valid) begin
            wr_acc_q <= 1'b1;
          end else if (ar_hs) begin
            state_q <= READ_DATA;
          end
        end
        WRITE_RESP: if (axil_req.b_ready) state_q <= IDLE;
        READ_DATA:  if (axil_req.r_ready) state_q <= IDLE;
        default:    state_q <= IDLE;
      endcase
    end
  end

  // response payloads
  always_ff @(posedge clk) begin
    if (wr_hs) begin
      b_resp_q <= wr_mapped ? RESP_OKAY : RESP_SLVERR;
    end
    if (ar_hs) begin
      r_data_q <= rd_data;
      r_resp_q <= rd_resp;
    end
  end

  always_comb begin
    axil_rsp          = '0;
    axil_rsp.aw_ready = wr_acc_q;
    axil_rsp.w_ready  = wr_acc_q;
    axil_rsp.b.valid  = (state_q == WRITE_RESP);
    axil_rsp.b.resp   = b_resp_q;
    axil_rsp.ar_ready = ar_hs;  // low until a read is offered
    axil_rsp.r.valid  = (state_q == READ_DATA);
    axil_rsp.r.data   = r_data_q;
    axil_rsp.r.resp   = r_resp_q;
  end

  assign cfg = cfg_q;

  a_one_resp: assert property (@(posedge clk) disable iff (!rst_n)
    !(axil_rsp.b.valid && axil_rsp.r.valid));

endmodule

// File: cdr_top.sv
`timescale 1ns/1ps
`include "cdr_defs.svh"

module cdr_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  cdr_pkg::sample_t       sample,
  input  logic                   sample_valid,
  output logic [`CDR_CODE_W-1:0] code,
  input  axil_pkg::axil_req_t    axil_req,
  output axil_pkg::axil_rsp_t    axil_rsp
);
  import cdr_pkg::*;

  decision_t              dec;         // detector out
  logic                   dec_valid;
  decision_t              fifo_dec;    // fifo head
  logic                   fifo_valid;
  logic                   fifo_ready;  // low while frozen
  logic                   ovf_pulse;
  loop_cfg_t              cfg;
  logic [`CDR_FREQ_W-1:0] freq;

  bbpd_decider u_bbpd (
    .clk          (clk),
    .rst_n        (rst_n),
    .sample       (sample),
    .sample_valid (sample_valid),
    .dec          (dec),
    .dec_valid    (dec_valid)
  );

  decision_fifo u_fifo (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_dec   (dec),
    .wr_valid (dec_valid),
    .rd_dec   (fifo_dec),
    .rd_valid (fifo_valid),
    .rd_ready (fifo_ready),
    .overflow (ovf_pulse)
  );

  loop_filter u_filter (
    .clk       (clk),
    .rst_n     (rst_n),
    .dec       (fifo_dec),
    .dec_valid (fifo_valid),
    .dec_ready (fifo_ready),
    .cfg       (cfg),
    .code      (code),
    .freq      (freq)
  );

  cdr_csr_axil u_csr (
    .clk            (clk),
    .rst_n          (rst_n),
    .axil_req       (axil_req),
    .axil_rsp       (axil_rsp),
    .stat_code      (code),
    .stat_freq      (freq),
    .overflow_pulse (ovf_pulse),
    .cfg            (cfg)
  );

endmodule

// File: tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
  output logic clk,
  output logic rst_n
);
  localparam real HALF_PERIOD = 2.0;  // 4 ns clock
  localparam int  RST_CYCLES  = 10;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // release on a falling edge between flop updates
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

// File: tb_cdr.sv
`timescale 1ns/1ps
`include "cdr_defs.svh"

module tb_cdr;
  import cdr_pkg::*;
  import axil_pkg::*;

  localparam int AXI_LIMIT     = 50;   // cycles per channel
  localparam int DRAIN_LIMIT   = 500;
  localparam int STABLE_CYCLES = 16;   // longer than fifo depth plus pipeline
  localparam int RESET_LIMIT   = 100;
  localparam int SETTLE        = 1;    // ns after the falling edge

  // model state in the filter's own widths
  typedef struct packed {
    logic [`CDR_PHASE_W-1:0] phase;
    logic [`CDR_FREQ_W-1:0]  freq;
  } model_t;

  logic                   clk;
  logic                   rst_n;
  sample_t                sample;
  logic                   sample_valid;
  logic [`CDR_CODE_W-1:0] code;
  axil_req_t              axil_req;
  axil_rsp_t              axil_rsp;

  model_t                 model;
  decision_e              exp_q[$];   // predicted decisions not yet filtered
  logic                   prev_data;  // own copy of the detector history
  logic                   have_prev;
  logic [7:0]             cur_phug;
  logic [7:0]             cur_frug;
  integer                 seed;
  logic [31:0]            rnd;
  logic [31:0]            rdata;
  int                     errors;
  int                     pass_cnt;
  int                     fail_cnt;
  int                     errs_at_start;
  int                     i;
  int                     cnt;
  logic                   hold_watch;  // code must not move while set
  logic [`CDR_CODE_W-1:0] held_code;

  tb_clkgen u_clkgen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  cdr_top uut (
    .clk          (clk),
    .rst_n        (rst_n),
    .sample       (sample),
    .sample_valid (sample_valid),
    .code         (code),
    .axil_req     (axil_req),
    .axil_rsp     (axil_rsp)
  );

  // alexander table on (prev data, edge, data)
  function automatic decision_e alexander_dec(input logic p, input logic e, input logic d);
    case ({p, e, d})
      3'b001, 3'b110: return DEC_EARLY;
      3'b011, 3'b100: return DEC_LATE;
      default:        return DEC_NONE;
    endcase
  endfunction

  // one accepted decision through the pi filter
  function automatic model_t filter_step(input model_t m, input decision_e d,
                                         input logic [7:0] phug, input logic [7:0] frug);
    model_t          n;
    int              s;
    logic signed [8:0] fslice;
    s      = (d == DEC_LATE) ? 1 : ((d == DEC_EARLY) ? -1 : 0);
    fslice = m.freq[14:6];  // old freq read as signed
    n.freq  = m.freq + 16'(s * int'(frug));
    n.phase = m.phase + 16'(int'(fslice)) + 16'(s * int'(phug));
    return n;
  endfunction

  task automatic abort_on_timeout(input string what);
    $display("Timeout at %0t: %s", $time, what);
    $display("*** TEST FAILED ***");
    $finish;
  endtask

  task automatic check_code(input string name, input logic [`CDR_CODE_W-1:0] got,
                            input logic [`CDR_CODE_W-1:0] exp);
    if (got !== exp) begin
      $display("Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_freq(input string name, input logic [`CDR_FREQ_W-1:0] got,
                            input logic [`CDR_FREQ_W-1:0] exp);
    if (got !== exp) begin
      $display("Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_gain(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_resp(input string name, input axil_resp_e got, input axil_resp_e exp);
    if (got !== exp) begin
      $display("Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input bit got, input bit exp);
    if (got !== exp) begin
      $display("Error at %0t: %s = %0b, expected %0b", $time, name, got, exp);
      errors++;
    end
  endtask

  // ready is sampled 1 ns after the falling edge and the handshake lands on the next rise
  task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output axil_resp_e resp);
    bit done;
    int n;
    @(negedge clk);
    axil_req.aw.addr  = addr;
    axil_req.aw.valid = 1'b1;
    axil_req.w.data   = data;
    axil_req.w.strb   = strb;
    axil_req.w.valid  = 1'b1;
    done = 1'b0;
    n    = 0;
    while (!done) begin
      #(SETTLE);
      done = axil_rsp.aw_ready && axil_rsp.w_ready;
      @(negedge clk);
      n++;
      if (!done && n > AXI_LIMIT) abort_on_timeout("no awready/wready on write");
    end
    axil_req.aw.valid = 1'b0;
    axil_req.w.valid  = 1'b0;
    axil_req.b_ready  = 1'b1;
    done = 1'b0;
    n    = 0;
    while (!done) begin
      #(SETTLE);
      if (axil_rsp.b.valid) begin
        done = 1'b1;
        resp = axil_rsp.b.resp;
      end
      @(negedge clk);
      n++;
      if (!done && n > AXI_LIMIT) abort_on_timeout("no write response");
    end
    axil_req.b_ready = 1'b0;
  endtask

  task automatic axil_read(input logic [31:0] addr, output logic [31:0] data,
                           output axil_resp_e resp);
    bit done;
    int n;
    @(negedge clk);
    axil_req.ar.addr  = addr;
    axil_req.ar.valid = 1'b1;
    done = 1'b0;
    n    = 0;
    while (!done) begin
      #(SETTLE);
      done = axil_rsp.ar_ready;
      @(negedge clk);
      n++;
      if (!done && n > AXI_LIMIT) abort_on_timeout("no arready on read");
    end
    axil_req.ar.valid = 1'b0;
    axil_req.r_ready  = 1'b1;
    done = 1'b0;
    n    = 0;
    while (!done) begin
      #(SETTLE);
      if (axil_rsp.r.valid) begin
        done = 1'b1;
        data = axil_rsp.r.data;
        resp = axil_rsp.r.resp;
      end
      @(negedge clk);
      n++;
      if (!done && n > AXI_LIMIT) abort_on_timeout("no read data");
    end
    axil_req.r_ready = 1'b0;
  endtask

  task automatic write_ok(input logic [31:0] addr, input logic [31:0] data,
                          input logic [3:0] strb);
    axil_resp_e resp;
    axil_write(addr, data, strb, resp);
    check_resp("bresp", resp, RESP_OKAY);
  endtask

  task automatic read_ok(input logic [31:0] addr, output logic [31:0] data);
    axil_resp_e resp;
    axil_read(addr, data, resp);
    check_resp("rresp", resp, RESP_OKAY);
  endtask

  // one unit interval with its prediction kept alongside
  task automatic send_sample(input sample_t s);
    decision_e d;
    @(negedge clk);
    sample       = s;
    sample_valid = 1'b1;
    d = have_prev ? alexander_dec(prev_data, s.edge_bit, s.data_bit) : DEC_NONE;
    if (d != DEC_NONE) exp_q.push_back(d);
    prev_data = s.data_bit;
    have_prev = 1'b1;
  endtask

  // picks data and edge from the current history to hit the wanted verdict
  task automatic send_dir(input decision_e d);
    sample_t s;
    case (d)
      DEC_LATE: begin
        s.data_bit = !prev_data;
        s.edge_bit = !prev_data;
      end
      DEC_EARLY: begin
        s.data_bit = !prev_data;
        s.edge_bit = prev_data;
      end
      default: begin
        s.data_bit = prev_data;
        s.edge_bit = 1'b0;
      end
    endcase
    send_sample(s);
  endtask

  task automatic stop_samples();
    @(negedge clk);
    sample_valid = 1'b0;
  endtask

  // drained once the code has not moved for a while
  task automatic wait_drain();
    logic [`CDR_CODE_W-1:0] last;
    int stable;
    int n;
    stop_samples();
    last   = code;
    stable = 0;
    n      = 0;
    while (stable < STABLE_CYCLES) begin
      @(negedge clk);
      if (code == last) begin
        stable++;
      end else begin
        stable = 0;
        last   = code;
      end
      n++;
      if (n > DRAIN_LIMIT) abort_on_timeout("code did not settle after the samples stopped");
    end
  endtask

  task automatic apply_model();
    while (exp_q.size() > 0) begin
      model = filter_step(model, exp_q.pop_front(), cur_phug, cur_frug);
    end
  endtask

  task automatic compare_model();
    logic [31:0] d;
    check_code("code", code, model.phase[15:5]);
    read_ok(`CDR_ADDR_CODE, d);
    check_code("CODE", d[`CDR_CODE_W-1:0], model.phase[15:5]);
    read_ok(`CDR_ADDR_FREQ, d);
    check_freq("FREQ", d[`CDR_FREQ_W-1:0], model.freq);
  endtask

  task automatic end_test(input int num, input string what, input int errs_before);
    if (errors == errs_before) begin
      pass_cnt++;
      $display("test %0d %s: ok", num, what);
    end else begin
      fail_cnt++;
      $display("test %0d %s: failed with %0d errors", num, what, errors - errs_before);
    end
  endtask

  // frozen loop must hold its code
  always @(negedge clk) begin
    if (hold_watch && code !== held_code) begin
      $display("Error at %0t: code = 0x%0h, expected 0x%0h", $time, code, held_code);
      errors++;
      held_code = code;  // report each move once
    end
  end

  initial begin
    sample       = '0;
    sample_valid = 1'b0;
    axil_req     = '0;
    model        = '0;
    prev_data    = 1'b0;
    have_prev    = 1'b0;
    cur_phug     = 8'(`CDR_PHUG_RST);
    cur_frug     = 8'(`CDR_FRUG_RST);
    seed         = 32'h1a18_eca9;
    errors       = 0;
    pass_cnt     = 0;
    fail_cnt     = 0;
    hold_watch   = 1'b0;
    held_code    = '0;

    cnt = 0;
    while (rst_n !== 1'b1) begin
      @(negedge clk);
      cnt++;
      if (cnt > RESET_LIMIT) abort_on_timeout("reset never released");
    end

    errs_at_start = errors;
    // idle bus right out of reset
    check_flag("awready", axil_rsp.aw_ready, 1'b0);
    check_flag("wready", axil_rsp.w_ready, 1'b0);
    check_flag("bvalid", axil_rsp.b.valid, 1'b0);
    check_flag("arready", axil_rsp.ar_ready, 1'b0);
    check_flag("rvalid", axil_rsp.r.valid, 1'b0);
    read_ok(`CDR_ADDR_GAIN, rdata);
    check_gain("GAIN.phug", rdata[7:0], cur_phug);
    check_gain("GAIN.frug", rdata[15:8], cur_frug);
    read_ok(`CDR_ADDR_CODE, rdata);
    check_code("CODE", rdata[`CDR_CODE_W-1:0], '0);
    read_ok(`CDR_ADDR_FREQ, rdata);
    check_freq("FREQ", rdata[`CDR_FREQ_W-1:0], '0);
    read_ok(`CDR_ADDR_STAT, rdata);
    check_flag("STAT.overflow", rdata[0], 1'b0);
    end_test(1, "reset values", errs_at_start);

    errs_at_start = errors;
    send_dir(DEC_NONE);  // primes the detector history
    send_dir(DEC_LATE);
    send_dir(DEC_LATE);
    send_dir(DEC_EARLY);
    wait_drain();
    apply_model();
    compare_model();
    end_test(2, "late late early", errs_at_start);

    errs_at_start = errors;
    cur_phug = 8'h20;
    cur_frug = 8'h05;
    write_ok(`CDR_ADDR_GAIN, {16'h0, cur_frug, cur_phug}, 4'b0011);
    for (i = 0; i < 200; i++) begin
      rnd = $random(seed);
      send_sample(sample_t'(rnd[1:0]));
    end
    wait_drain();
    apply_model();
    compare_model();
    end_test(3, "random samples", errs_at_start);

    errs_at_start = errors;
    write_ok(`CDR_ADDR_CTRL, 32'h1, 4'h1);  // freeze
    held_code  = code;
    hold_watch = 1'b1;
    send_dir(DEC_LATE);
    send_dir(DEC_EARLY);
    send_dir(DEC_LATE);
    send_dir(DEC_LATE);
    send_dir(DEC_NONE);
    send_dir(DEC_EARLY);
    send_dir(DEC_LATE);  // six decisions total
    stop_samples();
    read_ok(`CDR_ADDR_CODE, rdata);
    check_code("CODE", rdata[`CDR_CODE_W-1:0], held_code);
    hold_watch = 1'b0;
    write_ok(`CDR_ADDR_CTRL, 32'h0, 4'h1);
    wait_drain();
    apply_model();
    compare_model();
    end_test(4, "freeze and release", errs_at_start);

    errs_at_start = errors;
    write_ok(`CDR_ADDR_CTRL, 32'h1, 4'h1);
    held_code  = code;
    hold_watch = 1'b1;
    for (i = 0; i < 12; i++) begin
      send_dir((i % 3 == 2) ? DEC_EARLY : DEC_LATE);
    end
    stop_samples();
    // fifo was empty, so only the oldest entries survive
    while (exp_q.size() > `CDR_FIFO_DEPTH) void'(exp_q.pop_back());
    read_ok(`CDR_ADDR_STAT, rdata);
    check_flag("STAT.overflow", rdata[0], 1'b1);
    hold_watch = 1'b0;
    write_ok(`CDR_ADDR_CTRL, 32'h0, 4'h1);
    wait_drain();
    apply_model();
    compare_model();
    write_ok(`CDR_ADDR_STAT, 32'h1, 4'h1);  // w1c
    read_ok(`CDR_ADDR_STAT, rdata);
    check_flag("STAT.overflow", rdata[0], 1'b0);
    end_test(5, "overflow", errs_at_start);

    errs_at_start = errors;
    begin : unmapped
      axil_resp_e resp;
      axil_read(32'h0000_0020, rdata, resp);
      check_resp("rresp", resp, RESP_SLVERR);
      axil_write(32'h0000_0024, 32'hdead_beef, 4'hf, resp);
      check_resp("bresp", resp, RESP_SLVERR);
    end
    end_test(6, "unmapped address", errs_at_start);

    $display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: src.f
+incdir+.
cdr_pkg.sv
axil_pkg.sv
bbpd_decider.sv
decision_fifo.sv
loop_filter.sv
cdr_csr_axil.sv
cdr_top.sv
tb_clkgen.sv
tb_cdr.sv

// File: Bender.yml
package:
  name: cdr_backend

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - cdr_pkg.sv
      - axil_pkg.sv
      - bbpd_decider.sv
      - decision_fifo.sv
      - loop_filter.sv
      - cdr_csr_axil.sv
      - cdr_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clkgen.sv
      - tb_cdr.sv
